// ==== hw/arena_pkg.sv ====
// Screen geometry, keycodes and per-tank tables
// Mode, colour, scan and control types shared by the arena design
`default_nettype none

package arena_pkg;

    //------------------------------------------------------------
    // Screen geometry, one clock per pixel
    //------------------------------------------------------------
    localparam int H_ACTIVE     = 64;
    localparam int H_TOTAL      = 80;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 74;

    localparam int V_ACTIVE     = 48;
    localparam int V_TOTAL      = 52;
    localparam int V_SYNC_START = 49;
    localparam int V_SYNC_END   = 51;

    localparam int COORD_W      = 7;

    // Tanks are solid squares
    localparam int N_TANKS      = 2;
    localparam int TANK_SIZE    = 8;
    localparam int X_MAX        = H_ACTIVE - TANK_SIZE;  // 56
    localparam int Y_MAX        = V_ACTIVE - TANK_SIZE;  // 40

    //------------------------------------------------------------
    // Types
    //------------------------------------------------------------
    typedef logic [7:0] keycode_t;

    typedef enum logic [1:0] {
        MODE_TITLE  = 2'd0,
        MODE_SELECT = 2'd1,
        MODE_PLAY   = 2'd2,
        MODE_OVER   = 2'd3
    } game_mode_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        logic               active;
        logic               hsync;   // Active low
        logic               vsync;   // Active low
    } scan_t;

    typedef struct packed {
        game_mode_t mode;
        logic [1:0] players;     // 1 or 2
        logic       tank_reset;
        logic       frame_tick;
    } ctrl_t;

    //------------------------------------------------------------
    // Keyboard usage codes
    //------------------------------------------------------------
    localparam keycode_t KEY_NONE    = 8'h00;
    localparam keycode_t KEY_SPACE   = 8'h2c;
    localparam keycode_t KEY_ENTER   = 8'h28;
    localparam keycode_t KEY_ENDGAME = 8'hff;
    localparam keycode_t KEY_RESTART = 8'h14;
    localparam keycode_t KEY_ONE     = 8'h1e;
    localparam keycode_t KEY_TWO     = 8'h1f;

    // Direction slots in TANK_KEYS
    localparam int DIR_UP    = 0;
    localparam int DIR_DOWN  = 1;
    localparam int DIR_LEFT  = 2;
    localparam int DIR_RIGHT = 3;

    // Tank 0 on W S A D, tank 1 on the arrow keys
    localparam keycode_t TANK_KEYS [N_TANKS][4] = '{
        '{8'h1a, 8'h16, 8'h04, 8'h07},
        '{8'h52, 8'h51, 8'h50, 8'h4f}
    };

    // Start x then y
    localparam logic [COORD_W-1:0] TANK_START [N_TANKS][2] = '{
        '{7'd8,  7'd32},
        '{7'd48, 7'd8}
    };

    localparam rgb_t TANK_COLOR [N_TANKS] = '{12'hf00, 12'h00f};

    // Background by mode: title, select, play, over
    localparam rgb_t MODE_BG [4] = '{12'h222, 12'h044, 12'h060, 12'h400};

endpackage

`default_nettype wire

// ==== hw/raster_timing.sv ====
// Pixel and line counters for the 64x48 screen
// Registered scan word with sync and blank strobes, plus the frame tick
`timescale 1ns/1ps
`default_nettype none

module raster_timing (
    input  logic            Clk,
    input  logic            arst_n,
    output arena_pkg::scan_t scan,
    output logic            frame_tick
);
    import arena_pkg::*;

    logic [COORD_W-1:0] h_cnt;
    logic [COORD_W-1:0] v_cnt;
    logic               h_last;
    logic               v_last;

    assign h_last = (h_cnt == COORD_W'(H_TOTAL - 1));
    assign v_last = (v_cnt == COORD_W'(V_TOTAL - 1));

    //------------------------------------------------------------
    // Counters, advancing every clock
    //------------------------------------------------------------
    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else
        begin
            h_cnt <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last)
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end
    end

    // Scan word describes the previous counter value
    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            scan       <= '{x: '0, y: '0, active: 1'b0, hsync: 1'b1, vsync: 1'b1};
            frame_tick <= 1'b0;
        end
        else
        begin
            scan.x      <= h_cnt;
            scan.y      <= v_cnt;
            scan.active <= (h_cnt < COORD_W'(H_ACTIVE)) && (v_cnt < COORD_W'(V_ACTIVE));
            scan.hsync  <= !((h_cnt >= COORD_W'(H_SYNC_START)) &&
                             (h_cnt <  COORD_W'(H_SYNC_END)));
            scan.vsync  <= !((v_cnt >= COORD_W'(V_SYNC_START)) &&
                             (v_cnt <  COORD_W'(V_SYNC_END)));
            frame_tick  <= (h_cnt == '0) && (v_cnt == COORD_W'(V_ACTIVE));  // End of visible area
        end
    end

endmodule

`default_nettype wire

// ==== hw/game_mode_ctrl.sv ====
// Seven-state game mode FSM driven by the keyboard
// Player count register, one-cycle tank reset, frame tick forwarding
`timescale 1ns/1ps
`default_nettype none

module game_mode_ctrl (
    input  logic               Clk,
    input  logic               arst_n,
    input  arena_pkg::keycode_t keycode,
    input  logic               frame_tick,
    output arena_pkg::ctrl_t    ctrl
);
    import arena_pkg::*;

    typedef enum logic [2:0] {
        ST_TITLE,
        ST_TITLE_REL,
        ST_SELECT,
        ST_SELECT_REL,
        ST_GAME_RST,
        ST_GAME,
        ST_OVER
    } state_t;

    state_t     state;
    state_t     next_state;
    logic [1:0] players;
    logic       player_seen;    // Player key seen since reset or restart
    logic       confirm_key;
    game_mode_t mode;

    assign confirm_key = (keycode == KEY_SPACE) || (keycode == KEY_ENTER);

    //------------------------------------------------------------
    // Next state
    //------------------------------------------------------------
    always_comb
    begin
        next_state = state;
        case (state)
            ST_TITLE:      if (player_seen && confirm_key) next_state = ST_TITLE_REL;
            ST_TITLE_REL:  if (!confirm_key) next_state = ST_SELECT;
            ST_SELECT:     if (confirm_key) next_state = ST_SELECT_REL;
            ST_SELECT_REL: if (keycode == KEY_NONE) next_state = ST_GAME_RST;
            ST_GAME_RST:   next_state = ST_GAME;
            ST_GAME:       if (keycode == KEY_ENDGAME) next_state = ST_OVER;
            ST_OVER:       if (keycode == KEY_RESTART) next_state = ST_TITLE;
            default:       next_state = ST_TITLE;
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= ST_TITLE;
        else
            state <= next_state;
    end

    // Player count is only picked on the title screen
    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            players     <= 2'd1;
            player_seen <= 1'b0;
        end
        else if (state == ST_OVER && keycode == KEY_RESTART)
        begin
            players     <= 2'd1;
            player_seen <= 1'b0;
        end
        else if (state == ST_TITLE && (keycode == KEY_ONE || keycode == KEY_TWO))
        begin
            players     <= (keycode == KEY_TWO) ? 2'd2 : 2'd1;
            player_seen <= 1'b1;
        end
    end

    //------------------------------------------------------------
    // Outputs
    //------------------------------------------------------------
    always_comb
    begin
        case (state)
            ST_TITLE, ST_TITLE_REL:   mode = MODE_TITLE;
            ST_SELECT, ST_SELECT_REL: mode = MODE_SELECT;
            ST_GAME_RST, ST_GAME:     mode = MODE_PLAY;
            default:                  mode = MODE_OVER;
        endcase
    end

    always_comb
    begin
        ctrl.mode       = mode;
        ctrl.players    = players;
        ctrl.tank_reset = (state == ST_GAME_RST);
        ctrl.frame_tick = frame_tick;
    end

endmodule

`default_nettype wire

// ==== hw/tank_unit.sv ====
// One tank: position register, key-driven stepping with clamping
// Registered per-pixel hit test against the tank square
`timescale 1ns/1ps
`default_nettype none

module tank_unit #(
    parameter int TANK_ID = 0
) (
    input  logic               Clk,
    input  logic               arst_n,
    input  arena_pkg::ctrl_t    ctrl,
    input  arena_pkg::keycode_t keycode,
    input  arena_pkg::scan_t    scan,
    output logic               hit,
    output arena_pkg::rgb_t     color
);
    import arena_pkg::*;

    logic [COORD_W-1:0] pos_x;
    logic [COORD_W-1:0] pos_y;
    logic               tank_active;
    logic               step_en;
    logic               in_x;
    logic               in_y;

    assign tank_active = (TANK_ID < int'(ctrl.players));
    assign step_en     = ctrl.frame_tick && (ctrl.mode == MODE_PLAY) && tank_active;

    //------------------------------------------------------------
    // Position, one pixel per frame in the key's direction
    //------------------------------------------------------------
    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pos_x <= TANK_START[TANK_ID][0];
            pos_y <= TANK_START[TANK_ID][1];
        end
        else if (ctrl.tank_reset)
        begin
            pos_x <= TANK_START[TANK_ID][0];
            pos_y <= TANK_START[TANK_ID][1];
        end
        else if (step_en)
        begin
            // Clamp at the arena edges
            if (keycode == TANK_KEYS[TANK_ID][DIR_UP] && pos_y != '0)
                pos_y <= pos_y - 1'b1;
            if (keycode == TANK_KEYS[TANK_ID][DIR_DOWN] && pos_y < COORD_W'(Y_MAX))
                pos_y <= pos_y + 1'b1;
            if (keycode == TANK_KEYS[TANK_ID][DIR_LEFT] && pos_x != '0)
                pos_x <= pos_x - 1'b1;
            if (keycode == TANK_KEYS[TANK_ID][DIR_RIGHT] && pos_x < COORD_W'(X_MAX))
                pos_x <= pos_x + 1'b1;
        end
    end

    // Square covers [pos, pos + TANK_SIZE) on both axes
    assign in_x = (scan.x >= pos_x) && (scan.x < pos_x + COORD_W'(TANK_SIZE));
    assign in_y = (scan.y >= pos_y) && (scan.y < pos_y + COORD_W'(TANK_SIZE));

    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
            hit <= 1'b0;
        else
            hit <= scan.active && (ctrl.mode == MODE_PLAY) && tank_active && in_x && in_y;
    end

    assign color = TANK_COLOR[TANK_ID];

endmodule

`default_nettype wire

// ==== hw/pixel_mixer.sv ====
// Pixel mixer: lowest-index tank over the mode background
// Blanking and a two-stage sync delay to line up with rgb
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
    input  logic                                Clk,
    input  logic                                arst_n,
    input  arena_pkg::scan_t                    scan,
    input  logic [arena_pkg::N_TANKS-1:0]       hit,
    input  arena_pkg::rgb_t [arena_pkg::N_TANKS-1:0] tank_color,
    input  arena_pkg::game_mode_t               mode,
    output arena_pkg::rgb_t                     rgb,
    output logic                                hsync,
    output logic                                vsync,
    output logic                                blank_n,
    output arena_pkg::game_mode_t               mode_out
);
    import arena_pkg::*;

    logic active_d;
    logic hsync_d;
    logic vsync_d;
    rgb_t pixel;

    //------------------------------------------------------------
    // Stage 1 matches the registered tank hits
    //------------------------------------------------------------
    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
        end
        else
        begin
            active_d <= scan.active;
            hsync_d  <= scan.hsync;
            vsync_d  <= scan.vsync;
        end
    end

    // Walk down so tank 0 ends up on top
    always_comb
    begin
        pixel = MODE_BG[mode];
        for (int i = N_TANKS - 1; i >= 0; i--)
        begin
            if (hit[i])
                pixel = tank_color[i];
        end
    end

    // Stage 2, output register
    always_ff @(posedge Clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rgb      <= '0;
            blank_n  <= 1'b0;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
            mode_out <= MODE_TITLE;
        end
        else
        begin
            rgb      <= active_d ? pixel : '0;  // Black in blanking
            blank_n  <= active_d;
            hsync    <= hsync_d;
            vsync    <= vsync_d;
            mode_out <= mode;
        end
    end

endmodule

`default_nettype wire

// ==== hw/tank_arena.sv ====
// Arena top level: mode FSM, raster timing, tank units and mixer
`timescale 1ns/1ps
`default_nettype none

module tank_arena (
    input  logic                  Clk,
    input  logic                  arst_n,
    input  arena_pkg::keycode_t    keycode,
    output arena_pkg::rgb_t        rgb,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  blank_n,
    output arena_pkg::game_mode_t  mode
);
    import arena_pkg::*;

    scan_t                scan;
    logic                 frame_tick;
    ctrl_t                ctrl;
    logic [N_TANKS-1:0]   hit;
    rgb_t [N_TANKS-1:0]   tank_color;

    raster_timing u_timing (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .scan       (scan),
        .frame_tick (frame_tick)
    );

    game_mode_ctrl u_mode (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .keycode    (keycode),
        .frame_tick (frame_tick),
        .ctrl       (ctrl)
    );

    //------------------------------------------------------------
    // Tank units
    //------------------------------------------------------------
    for (genvar i = 0; i < N_TANKS; i++)
    begin : g_tank
        tank_unit #(.TANK_ID(i)) u_tank (
            .Clk     (Clk),
            .arst_n  (arst_n),
            .ctrl    (ctrl),
            .keycode (keycode),
            .scan    (scan),
            .hit     (hit[i]),
            .color   (tank_color[i])
        );
    end

    pixel_mixer u_mixer (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .scan       (scan),
        .hit        (hit),
        .tank_color (tank_color),
        .mode       (ctrl.mode),
        .rgb        (rgb),
        .hsync      (hsync),
        .vsync      (vsync),
        .blank_n    (blank_n),
        .mode_out   (mode)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Clock and reset source for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic Clk,
    output logic arst_n
);
    localparam int HALF_PERIOD_NS = 2;    // 4 ns period
    localparam int RESET_CYCLES   = 8;

    initial
    begin
        Clk = 1'b0;
        forever
            #HALF_PERIOD_NS Clk = ~Clk;
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge Clk);
        #1;
        arst_n = 1'b1;    // Release just after an edge
    end

endmodule

`default_nettype wire

// ==== tests/arena_monitor.sv ====
// Frame capture and comparison against expected mode and probe pixels
// Prints one line per test and keeps the pass and fail counts
`timescale 1ns/1ps
`default_nettype none

module arena_monitor (
    input  logic                  Clk,
    input  arena_pkg::rgb_t       rgb,
    input  logic                  hsync,
    input  logic                  vsync,
    input  logic                  blank_n,
    input  arena_pkg::game_mode_t mode,
    input  logic                  check_req,
    input  logic [127:0]          test_name,
    input  arena_pkg::game_mode_t exp_mode,
    input  logic [1:0][6:0]       probe_x,
    input  logic [1:0][6:0]       probe_y,
    input  arena_pkg::rgb_t [1:0] probe_rgb,
    output logic                  check_done,
    output int                    tests_done,
    output int                    tests_failed
);
    import arena_pkg::*;

    localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;

    rgb_t       frame [FRAME_PIXELS];    // Row-major visible pixels
    game_mode_t seen_mode;
    int         hsync_errs;

    // Sampled on the falling edge, away from the output registers
    task automatic capture_frame;
        int n;
        int col;
        n = 0;
        col = 0;
        hsync_errs = 0;
        while (vsync)
            @(negedge Clk);
        while (!vsync)
            @(negedge Clk);
        while (!blank_n)
            @(negedge Clk);
        seen_mode = mode;
        while (n < FRAME_PIXELS)
        begin
            if (blank_n)
            begin
                frame[n] = rgb;
                n++;
            end
            // Line position counted from the first visible pixel
            if (hsync !== !((col >= H_SYNC_START) && (col < H_SYNC_END)))
                hsync_errs++;
            col = (col == H_TOTAL - 1) ? 0 : col + 1;
            @(negedge Clk);
        end
    endtask

    //------------------------------------------------------------
    // Comparison
    //------------------------------------------------------------
    task automatic compare_frame;
        int fails;
        int idx;
        fails = 0;
        if (seen_mode !== exp_mode)
        begin
            $display("Fail at %0t ns: %0s mode is %0d, expected %0d",
                     $time, test_name, seen_mode, exp_mode);
            fails++;
        end
        for (int p = 0; p < 2; p++)
        begin
            idx = int'(probe_y[p]) * H_ACTIVE + int'(probe_x[p]);
            if (frame[idx] !== probe_rgb[p])
            begin
                $display("Fail at %0t ns: %0s pixel (%0d,%0d) is %03h, expected %03h",
                         $time, test_name, probe_x[p], probe_y[p], frame[idx], probe_rgb[p]);
                fails++;
            end
        end
        if (hsync_errs != 0)
        begin
            $display("Fail at %0t ns: %0s hsync wrong on %0d clocks of the frame",
                     $time, test_name, hsync_errs);
            fails++;
        end
        tests_done++;
        if (fails != 0)
            tests_failed++;
        $display("Test %0d %0s: %s", tests_done, test_name, (fails == 0) ? "passed" : "failed");
    endtask

    initial
    begin
        check_done   = 1'b0;
        tests_done   = 0;
        tests_failed = 0;
        forever
        begin
            wait (check_req);
            capture_frame();
            compare_frame();
            check_done = 1'b1;
            wait (!check_req);
            check_done = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tests/arena_checker.sv ====
// Concurrent checks on blanking, sync alignment and mode order
`timescale 1ns/1ps
`default_nettype none

module arena_checker (
    input logic                  Clk,
    input logic                  arst_n,
    input arena_pkg::rgb_t       rgb,
    input logic                  hsync,
    input logic                  vsync,
    input logic                  blank_n,
    input arena_pkg::game_mode_t mode
);
    import arena_pkg::*;

    int blank_errs = 0;
    int sync_errs  = 0;
    int mode_errs  = 0;

    // Black outside the visible area
    a_blank_black: assert property (@(posedge Clk) disable iff (!arst_n)
        !blank_n |-> (rgb == '0))
    else
    begin
        blank_errs = blank_errs + 1;
        $error("rgb not black during blanking");
    end

    // Vertical sync edges fall inside the horizontal sync high time
    a_sync_align: assert property (@(posedge Clk) disable iff (!arst_n)
        (vsync != $past(vsync)) |-> hsync)
    else
    begin
        sync_errs = sync_errs + 1;
        $error("vsync changed while hsync was low");
    end

    a_no_title_to_play: assert property (@(posedge Clk) disable iff (!arst_n)
        (mode == MODE_TITLE) |=> (mode != MODE_PLAY))
    else
    begin
        mode_errs = mode_errs + 1;
        $error("mode went from title straight to play");
    end

endmodule

bind tank_arena arena_checker u_checker (
    .Clk     (Clk),
    .arst_n  (arst_n),
    .rgb     (rgb),
    .hsync   (hsync),
    .vsync   (vsync),
    .blank_n (blank_n),
    .mode    (mode)
);

`default_nettype wire

// ==== tests/tb_arena.sv ====
// Testbench top with test vector loading, keycode driving and watchdog
// Collects monitor and assertion counts for the final status
`timescale 1ns/1ps
`default_nettype none

module tb_arena;
    import arena_pkg::*;

    localparam int    MAX_TESTS    = 32;
    localparam int    FRAME_CYCLES = 4160;    // 80 x 52
    localparam int    CLK_NS       = 4;
    localparam string DATA_FILE    = "tests/arena_testdata.txt";

    logic            Clk;
    logic            arst_n;
    keycode_t        keycode;
    rgb_t            rgb;
    logic            hsync;
    logic            vsync;
    logic            blank_n;
    game_mode_t      mode;

    // Expected values handed to the monitor
    logic            check_req;
    logic            check_done;
    logic [127:0]    cur_name;
    game_mode_t      cur_mode;
    logic [1:0][6:0] cur_px;
    logic [1:0][6:0] cur_py;
    rgb_t [1:0]      cur_rgb;
    int              tests_done;
    int              tests_failed;

    // Test table
    logic [127:0]    t_name [MAX_TESTS];
    logic            t_rnd  [MAX_TESTS];
    keycode_t        t_key  [MAX_TESTS];
    int              t_hold [MAX_TESTS];
    game_mode_t      t_mode [MAX_TESTS];
    logic [1:0][6:0] t_px   [MAX_TESTS];
    logic [1:0][6:0] t_py   [MAX_TESTS];
    rgb_t [1:0]      t_rgb  [MAX_TESTS];
    int              n_tests;
    int              seed = 98;
    logic            loaded = 1'b0;
    longint          limit_ns;

    tb_clock u_clock (
        .Clk    (Clk),
        .arst_n (arst_n)
    );

    tank_arena dut0 (
        .Clk     (Clk),
        .arst_n  (arst_n),
        .keycode (keycode),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync),
        .blank_n (blank_n),
        .mode    (mode)
    );

    arena_monitor u_monitor (
        .Clk          (Clk),
        .rgb          (rgb),
        .hsync        (hsync),
        .vsync        (vsync),
        .blank_n      (blank_n),
        .mode         (mode),
        .check_req    (check_req),
        .test_name    (cur_name),
        .exp_mode     (cur_mode),
        .probe_x      (cur_px),
        .probe_y      (cur_py),
        .probe_rgb    (cur_rgb),
        .check_done   (check_done),
        .tests_done   (tests_done),
        .tests_failed (tests_failed)
    );

    //------------------------------------------------------------
    // Test table loading
    //------------------------------------------------------------
    task automatic load_tests(output logic ok);
        int           fd;
        int           got;
        int           hold;
        int           m;
        int           x0;
        int           y0;
        int           x1;
        int           y1;
        logic [11:0]  c0;
        logic [11:0]  c1;
        logic [7:0]   kv;
        logic [127:0] name_tok;
        string        key_tok;
        string        line;
        n_tests = 0;
        fd = $fopen(DATA_FILE, "r");
        ok = (fd != 0);
        if (ok)
        begin
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line.getc(0) != "#")    // Skip comments
                begin
                    got = $sscanf(line, "%s %s %d %d %d %d %h %d %d %h", name_tok, key_tok,
                                  hold, m, x0, y0, c0, x1, y1, c1);
                    if (got == 10 && n_tests < MAX_TESTS)
                    begin
                        kv = 8'h00;
                        t_rnd[n_tests] = (key_tok == "rnd");
                        if (key_tok != "rnd")
                            got = $sscanf(key_tok, "%h", kv);
                        t_name[n_tests]    = name_tok;
                        t_key[n_tests]     = kv;
                        t_hold[n_tests]    = hold;
                        t_mode[n_tests]    = game_mode_t'(m);
                        t_px[n_tests][0]   = 7'(x0);
                        t_py[n_tests][0]   = 7'(y0);
                        t_rgb[n_tests][0]  = c0;
                        t_px[n_tests][1]   = 7'(x1);
                        t_py[n_tests][1]   = 7'(y1);
                        t_rgb[n_tests][1]  = c1;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Keys that would steer the FSM or a tank
    function automatic logic is_meaningful(input keycode_t k);
        logic used;
        used = (k == KEY_NONE) || (k == KEY_SPACE) || (k == KEY_ENTER) ||
               (k == KEY_ENDGAME) || (k == KEY_RESTART) || (k == KEY_ONE) || (k == KEY_TWO);
        for (int t = 0; t < N_TANKS; t++)
            for (int d = 0; d < 4; d++)
                if (k == TANK_KEYS[t][d])
                    used = 1'b1;
        return used;
    endfunction

    task automatic pick_filler(output keycode_t k);
        k = keycode_t'($random(seed));
        while (is_meaningful(k))
            k = keycode_t'($random(seed));
    endtask

    //------------------------------------------------------------
    // One test: key, hold for some frames, then a frame check
    //------------------------------------------------------------
    task automatic run_test(input int i);
        keycode_t k;
        k = t_key[i];
        if (t_rnd[i])
            pick_filler(k);
        @(posedge Clk);
        #1;
        keycode = k;
        repeat (t_hold[i]) @(negedge vsync);
        @(posedge Clk);
        #1;
        cur_name  = t_name[i];
        cur_mode  = t_mode[i];
        cur_px    = t_px[i];
        cur_py    = t_py[i];
        cur_rgb   = t_rgb[i];
        check_req = 1'b1;
        wait (check_done);
        check_req = 1'b0;
        wait (!check_done);
    endtask

    initial
    begin
        logic ok;
        int   total_frames;
        int   assert_errs;
        keycode   = KEY_NONE;
        check_req = 1'b0;
        cur_name  = '0;
        cur_mode  = MODE_TITLE;
        cur_px    = '0;
        cur_py    = '0;
        cur_rgb   = '0;
        load_tests(ok);
        if (!ok || n_tests == 0)
        begin
            $display("Could not read any test from %s", DATA_FILE);
            $display("STATUS: FAIL");
            $finish;
        end
        else
        begin
            total_frames = 0;
            for (int i = 0; i < n_tests; i++)
                total_frames += t_hold[i] + 2;
            limit_ns = longint'(total_frames) * FRAME_CYCLES * CLK_NS;
            loaded   = 1'b1;
            wait (arst_n);
            for (int i = 0; i < n_tests; i++)
                run_test(i);
            assert_errs = dut0.u_checker.blank_errs + dut0.u_checker.sync_errs +
                          dut0.u_checker.mode_errs;
            $display("Tests run %0d, failed %0d, assertion failures %0d",
                     tests_done, tests_failed, assert_errs);
            if (tests_failed == 0 && assert_errs == 0 && tests_done == n_tests)
                $display("STATUS: PASS");
            else
                $display("STATUS: FAIL");
            $finish;
        end
    end

    // Watchdog
    initial
    begin
        wait (loaded);
        #(limit_ns);
        $display("Timeout after %0d ns, a test never completed", limit_ns);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/arena_testdata.txt ====
# name key(hex or rnd) hold_frames mode(0 title 1 select 2 play 3 over)
# x0 y0 rgb0 x1 y1 rgb1 are two probe pixels with expected colours (hex)
reset      00  1 0  8 32 222 48  8 222
two        1f  1 0  8 32 222 48  8 222
enter      28  1 0  8 32 222 48  8 222
release    rnd 1 1  8 32 044 48  8 044
confirm    28  1 1  8 32 044 48  8 044
start      00  1 2 10 34 f00 50 10 00f
floor      00  1 2  0  0 060  7 32 060
right5     07  5 2 20 39 f00 12 32 060
up_clamp   52 12 2 48  0 00f 48  8 060
t1_down    51 28 2 48 35 00f 48 27 060
overlap    07 31 2 49 33 f00 53 29 00f
endgame    ff  1 3 49 33 400  8 32 400
restart    14  1 0 49 33 222  0  0 222
title_key  07  2 0  8 32 222 48  8 222
one        1e  1 0  8 32 222 48  8 222
enter1p    28  1 0  8 32 222 48  8 222
release1p  rnd 1 1  8 32 044 48  8 044
sel_key    4f  2 1  8 32 044 48  8 044
confirm1p  28  1 1  8 32 044 48  8 044
start1p    00  1 2  8 32 f00 48  8 060
t1_keys    50  3 2  8 32 f00 45  8 060

// ==== files.f ====
hw/arena_pkg.sv
hw/raster_timing.sv
hw/game_mode_ctrl.sv
hw/tank_unit.sv
hw/pixel_mixer.sv
hw/tank_arena.sv
tests/tb_clock.sv
tests/arena_monitor.sv
tests/arena_checker.sv
tests/tb_arena.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_arena
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: sim clean

# Build, run, and succeed only when the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk -v msg="$(PASS_MSG)" '{ print } $$0 == msg { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
